//--- filelist.f
src/mipsIsaPkg.sv
src/pipeCtrlPkg.sv
src/instDecoder.sv
src/regFile.sv
src/hazardUnit.sv
src/executeUnit.sv
src/mipsDatapath.sv
verif/mipsDatapath_assert.sv
verif/tbMipsDatapath.sv

//--- Bender.yml
package:
  name: mips_datapath

sources:
  - files:
      - src/mipsIsaPkg.sv
      - src/pipeCtrlPkg.sv
      - src/instDecoder.sv
      - src/regFile.sv
      - src/hazardUnit.sv
      - src/executeUnit.sv
      - src/mipsDatapath.sv
  - target: simulation
    files:
      - verif/mipsDatapath_assert.sv
      - verif/tbMipsDatapath.sv

//--- verif/tbMipsDatapath.sv
`timescale 1ns/1ps

module tbMipsDatapath import mipsIsaPkg::*, pipeCtrlPkg::*; ();

    logic                 clk;
    logic                 rstN;
    logic [dataWidth-1:0] instAddr;
    logic                 instEn;
    logic [dataWidth-1:0] instData;
    logic [dataWidth-1:0] instOff;
    logic                 memEn;
    logic                 memWe;
    logic [dataWidth-1:0] memAddr;
    logic [dataWidth-1:0] memWdata;
    logic [dataWidth-1:0] memRdata;
    commit_t              commit;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:63];
    logic [31:0] modelMem [0:63];
    logic [31:0] modelRegs [0:31];
    commit_t     expList [0:255];
    logic [31:0] storeAddrList [0:127];
    logic [31:0] storeDataList [0:127];
    int          commitCount;
    int          storeCount;
    int          cIdx;
    int          sIdx;
    int          seed = 32'h62f7;
    logic [31:0] finalPc;
    logic        modelDone;

    // expected queue heads for the bound checker
    commit_t     expCommit;
    logic        commitLeft;
    logic [31:0] expStoreAddr;
    logic [31:0] expStoreData;
    logic        storeLeft;

    mipsDatapath dut_i (
        .clk        (clk),
        .rstN_i     (rstN),
        .instAddr_o (instAddr),
        .instEn_o   (instEn),
        .instData_i (instData),
        .memEn_o    (memEn),
        .memWe_o    (memWe),
        .memAddr_o  (memAddr),
        .memWdata_o (memWdata),
        .memRdata_i (memRdata),
        .commit_o   (commit)
    );

    bind mipsDatapath mipsDatapath_assert assert_i (
        .clk            (clk),
        .rstN_i         (rstN_i),
        .commit_i       (commit_o),
        .memEn_i        (memEn_o),
        .memWe_i        (memWe_o),
        .memAddr_i      (memAddr_o),
        .memWdata_i     (memWdata_o),
        .expCommit_i    (tbMipsDatapath.expCommit),
        .commitLeft_i   (tbMipsDatapath.commitLeft),
        .expStoreAddr_i (tbMipsDatapath.expStoreAddr),
        .expStoreData_i (tbMipsDatapath.expStoreData),
        .storeLeft_i    (tbMipsDatapath.storeLeft)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // both memories answer in the same cycle
    assign instOff = instAddr - resetVector;
    assign instData = (instEn && (instOff < 32'd1024)) ? imem[instOff[9:2]] : '0;
    assign memRdata = memEn ? dmem[memAddr[7:2]] : '0;

    always @(posedge clk) begin
        if (memEn && memWe) begin
            dmem[memAddr[7:2]] <= memWdata;
        end
    end

    assign commitLeft = cIdx < commitCount;
    assign expCommit = expList[cIdx[7:0]];
    assign storeLeft = sIdx < storeCount;
    assign expStoreAddr = storeAddrList[sIdx[6:0]];
    assign expStoreData = storeDataList[sIdx[6:0]];

    always @(posedge clk) begin
        if (rstN && commit.valid) begin
            cIdx <= cIdx + 1;
        end
        if (rstN && memEn && memWe) begin
            sIdx <= sIdx + 1;
        end
    end

    function automatic int unsigned pick(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] encR(funct_t fn, regIdx_t rs, regIdx_t rt, regIdx_t rd,
                                         logic [4:0] sa);
        return {opSpecial, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] encI(opcode_t op, regIdx_t rs, regIdx_t rt,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // one random alu, load, store or shift word
    task automatic emitRandom(inout int p, inout regIdx_t lastDest);
        funct_t  aluFn [8] = '{fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu};
        opcode_t immOp [5] = '{opAddiu, opAndi, opOri, opSlti, opLui};
        regIdx_t rs;
        regIdx_t rt;
        regIdx_t rd;
        opcode_t op;
        int      kind;
        rs = (pick(2) == 0) ? lastDest : regIdx_t'(pick(16)); // frequent back-to-back use
        rt = (pick(2) == 0) ? lastDest : regIdx_t'(pick(16));
        rd = regIdx_t'(pick(16));
        kind = pick(10);
        case (kind)
            0, 1, 2, 3, 4: imem[p] = encR(aluFn[pick(8)], rs, rt, rd, 5'd0);
            5, 6: begin
                op = immOp[pick(5)];
                imem[p] = encI(op, rs, rd, 16'(pick(65536)));
            end
            7: imem[p] = encI(opLw, '0, rd, 16'(pick(64) * 4));
            8: imem[p] = encI(opSw, '0, rt, 16'(pick(64) * 4));
            default: imem[p] = encR(pick(2) ? fnSll : fnSrl, '0, rt, rd, 5'(pick(32)));
        endcase
        if (kind != 8) begin
            lastDest = rd;
        end
        p++;
    endtask

    task automatic buildProgram();
        int          p;
        regIdx_t     lastDest;
        logic [31:0] target;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = (i * 4) * 32'h9e37_79b9 ^ 32'h0f1e_2d3c;
        end
        p = 0;
        for (int r = 1; r <= 8; r++) begin
            imem[p] = encI(opLui, '0, regIdx_t'(r), 16'(pick(65536)));
            imem[p + 1] = encI(opOri, regIdx_t'(r), regIdx_t'(r), 16'(pick(65536)));
            p += 2;
        end
        lastDest = 5'd8;
        for (int k = 0; k < 60; k++) begin
            if (k == 20 || k == 40) begin
                // skip two words with a nop delay slot
                if (k == 20) begin
                    imem[p] = encI(opBeq, lastDest, lastDest, 16'd3);
                end else begin
                    imem[p] = encI(opBne, lastDest, '0, 16'd3);
                end
                imem[p + 1] = instNop;
                p += 2;
                emitRandom(p, lastDest);
                emitRandom(p, lastDest);
            end else if (k == 30) begin
                target = resetVector + (p + 3) * 4;
                imem[p] = {opJ, target[27:2]};
                p++;
                emitRandom(p, lastDest); // delay slot
                emitRandom(p, lastDest); // never fetched
            end
            emitRandom(p, lastDest);
        end
        finalPc = resetVector + p * 4;
        imem[p] = {opJ, finalPc[27:2]};
        imem[p + 1] = instNop;
    endtask

    // architectural model stepping one word at a time with delay slots
    task automatic runModel();
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] newNpc;
        logic [31:0] off;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] imSe;
        logic [31:0] imZe;
        logic [31:0] addr;
        logic [31:0] pcPlus4;
        logic        wr;
        regIdx_t     dst;
        int          steps;
        commitCount = 0;
        storeCount = 0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            modelMem[i] = dmem[i];
        end
        pc = resetVector;
        npc = pc + 4;
        steps = 0;
        while (pc != finalPc && steps < 1000) begin
            off = pc - resetVector;
            inst = imem[off[9:2]];
            a = modelRegs[inst[25:21]];
            b = modelRegs[inst[20:16]];
            imSe = {{16{inst[15]}}, inst[15:0]};
            imZe = {16'b0, inst[15:0]};
            addr = a + imSe;
            pcPlus4 = pc + 4;
            wr = 1'b1;
            dst = inst[20:16];
            res = '0;
            newNpc = npc + 4;
            case (inst[31:26])
                6'h00: begin
                    dst = inst[15:11];
                    case (inst[5:0])
                        6'h00:   res = b << inst[10:6];
                        6'h02:   res = b >> inst[10:6];
                        6'h21:   res = a + b;
                        6'h23:   res = a - b;
                        6'h24:   res = a & b;
                        6'h25:   res = a | b;
                        6'h26:   res = a ^ b;
                        6'h27:   res = ~(a | b);
                        6'h2a:   res = {31'b0, $signed(a) < $signed(b)};
                        6'h2b:   res = {31'b0, a < b};
                        default: wr = 1'b0;
                    endcase
                end
                6'h09: res = a + imSe;
                6'h0a: res = {31'b0, $signed(a) < $signed(imSe)};
                6'h0c: res = a & imZe;
                6'h0d: res = a | imZe;
                6'h0f: res = {inst[15:0], 16'b0};
                6'h23: res = modelMem[addr[7:2]];
                6'h2b: begin
                    wr = 1'b0;
                    modelMem[addr[7:2]] = b;
                    storeAddrList[storeCount] = addr;
                    storeDataList[storeCount] = b;
                    storeCount++;
                end
                6'h04, 6'h05: begin
                    wr = 1'b0;
                    if ((a == b) == (inst[31:26] == 6'h04)) begin
                        newNpc = pcPlus4 + {imSe[29:0], 2'b00};
                    end
                end
                6'h02: begin
                    wr = 1'b0;
                    newNpc = {pcPlus4[31:28], inst[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != '0) begin
                modelRegs[dst] = res;
                expList[commitCount] = '{valid: 1'b1, pc: pc, regNum: dst, data: res};
                commitCount++;
            end
            pc = npc;
            npc = newNpc;
            steps++;
        end
        modelDone = (pc == finalPc);
    endtask

    always @(negedge clk) begin
        if (dut_i.assert_i.errCount != 0) begin
            $display("** FAIL **");
            $fatal(1, "assertion failed at %0t", $time);
        end
    end

    initial begin
        int cycles;
        rstN = 1'b0;
        cIdx = 0;
        sIdx = 0;
        buildProgram();
        runModel();
        if (!modelDone) begin
            $display("reference model never reached the final loop");
            $display("** FAIL **");
            $fatal(1, "model did not finish");
        end else begin
            repeat (4) @(negedge clk);
            rstN = 1'b1;
            cycles = 0;
            while (!(cIdx == commitCount && sIdx == storeCount && instAddr == finalPc)
                   && cycles < 3000) begin
                @(negedge clk);
                cycles++;
            end
            if (cycles >= 3000) begin
                $display("timeout: DUT never reached the final loop with all commits");
                $display("** FAIL **");
                $fatal(1, "timeout");
            end else begin
                for (int i = 0; i < 8; i++) begin
                    @(negedge clk); // drain so that extra commits trip the checker
                end
                if (dut_i.assert_i.errCount == 0 && cIdx == commitCount) begin
                    $display("** PASS **");
                    $finish;
                end else begin
                    $display("** FAIL **");
                    $fatal(1, "checks failed");
                end
            end
        end
    end

endmodule

//--- verif/mipsDatapath_assert.sv
`timescale 1ns/1ps

module mipsDatapath_assert import mipsIsaPkg::*, pipeCtrlPkg::*; (
    input logic                 clk,
    input logic                 rstN_i,
    input commit_t              commit_i,
    input logic                 memEn_i,
    input logic                 memWe_i,
    input logic [dataWidth-1:0] memAddr_i,
    input logic [dataWidth-1:0] memWdata_i,
    input commit_t              expCommit_i,
    input logic                 commitLeft_i,
    input logic [dataWidth-1:0] expStoreAddr_i,
    input logic [dataWidth-1:0] expStoreData_i,
    input logic                 storeLeft_i
);

    int errCount = 0;

    resetQuiet: assert property (@(posedge clk)
        !rstN_i |-> !commit_i.valid && !memEn_i && !memWe_i)
        else begin
            errCount++;
            $error("commit or memory strobe active during reset");
        end

    noExtraCommit: assert property (@(posedge clk) disable iff (!rstN_i)
        commit_i.valid |-> commitLeft_i)
        else begin
            errCount++;
            $error("commit after the last expected one");
        end

    // in-order retirement against the model
    commitMatch: assert property (@(posedge clk) disable iff (!rstN_i)
        commit_i.valid && commitLeft_i |-> commit_i.pc == expCommit_i.pc
            && commit_i.regNum == expCommit_i.regNum && commit_i.data == expCommit_i.data)
        else begin
            errCount++;
            $error("Mismatch at %0t: commit pc %h r%0d=%h, expected pc %h r%0d=%h", $time,
                   $sampled(commit_i.pc), $sampled(commit_i.regNum), $sampled(commit_i.data),
                   $sampled(expCommit_i.pc), $sampled(expCommit_i.regNum),
                   $sampled(expCommit_i.data));
        end

    noExtraStore: assert property (@(posedge clk) disable iff (!rstN_i)
        memEn_i && memWe_i |-> storeLeft_i)
        else begin
            errCount++;
            $error("store after the last expected one");
        end

    storeMatch: assert property (@(posedge clk) disable iff (!rstN_i)
        memEn_i && memWe_i && storeLeft_i |-> memAddr_i == expStoreAddr_i
            && memWdata_i == expStoreData_i)
        else begin
            errCount++;
            $error("Mismatch at %0t: store %h to %h, expected %h to %h", $time,
                   $sampled(memWdata_i), $sampled(memAddr_i),
                   $sampled(expStoreData_i), $sampled(expStoreAddr_i));
        end

endmodule

//--- src/mipsDatapath.sv
`timescale 1ns/1ps

module mipsDatapath import mipsIsaPkg::*, pipeCtrlPkg::*; (
    input  logic                 clk,
    input  logic                 rstN_i,
    // instruction side
    output logic [dataWidth-1:0] instAddr_o,
    output logic                 instEn_o,
    input  logic [dataWidth-1:0] instData_i,
    // data side
    output logic                 memEn_o,
    output logic                 memWe_o,
    output logic [dataWidth-1:0] memAddr_o,
    output logic [dataWidth-1:0] memWdata_o,
    input  logic [dataWidth-1:0] memRdata_i,
    output commit_t              commit_o
);

    logic [dataWidth-1:0] pcF;
    logic [dataWidth-1:0] pcNext;
    logic [dataWidth-1:0] pcPlus4F;
    logic                 fetchEn;  // low until the first edge after reset

    logic [dataWidth-1:0] pcD;
    logic [dataWidth-1:0] pcPlus4D;
    instWord_t            instD;
    ctrl_t                ctrlD;
    logic [dataWidth-1:0] immD;
    logic [dataWidth-1:0] jumpTarget;
    logic [dataWidth-1:0] rsValD;
    logic [dataWidth-1:0] rtValD;
    regIdx_t              hazRs;
    regIdx_t              hazRt;

    exStage_t             exReg;
    memStage_t            memReg;
    wbStage_t             wbReg;

    fwdSel_t              fwdA;
    fwdSel_t              fwdB;
    logic                 stall;
    logic                 squash;
    logic [dataWidth-1:0] aluOutE;
    logic [dataWidth-1:0] storeDataE;
    logic                 branchTaken;
    logic [dataWidth-1:0] branchTarget;
    logic [dataWidth-1:0] memResult;

    assign pcPlus4F = pcF + 32'd4;
    assign instAddr_o = pcF;
    assign instEn_o = fetchEn;

    always_comb begin
        if (branchTaken) begin
            pcNext = branchTarget;
        end else if (ctrlD.jump) begin
            pcNext = jumpTarget; // delay slot is the word now in fetch
        end else if (stall || !fetchEn) begin
            pcNext = pcF;
        end else begin
            pcNext = pcPlus4F;
        end
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            pcF <= resetVector;
            fetchEn <= 1'b0;
        end else begin
            pcF <= pcNext;
            fetchEn <= 1'b1;
        end
    end

    // decode register
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            pcD <= '0;
            instD <= instNop;
        end else if (squash || !fetchEn) begin
            pcD <= pcF;
            instD <= instNop;
        end else if (!stall) begin
            pcD <= pcF;
            instD <= instData_i;
        end
    end

    assign pcPlus4D = pcD + 32'd4;

    instDecoder decoder_i (
        .inst_i       (instD),
        .pcPlus4_i    (pcPlus4D),
        .ctrl_o       (ctrlD),
        .imm_o        (immD),
        .jumpTarget_o (jumpTarget)
    );

    regFile regFile_i (
        .clk      (clk),
        .rstN_i   (rstN_i),
        .raddrA_i (instD.r.rs),
        .raddrB_i (instD.r.rt),
        .rdataA_o (rsValD),
        .rdataB_o (rtValD),
        .we_i     (wbReg.regWrite),
        .waddr_i  (wbReg.dest),
        .wdata_i  (wbReg.result)
    );

    // j keeps its target in the rs/rt fields
    assign hazRs = ctrlD.jump ? '0 : instD.r.rs;
    assign hazRt = ctrlD.jump ? '0 : instD.r.rt;

    hazardUnit hazard_i (
        .decRs_i       (hazRs),
        .decRt_i       (hazRt),
        .exRs_i        (exReg.rs),
        .exRt_i        (exReg.rt),
        .exCtrl_i      (exReg.ctrl),
        .memCtrl_i     (memReg.ctrl),
        .wbRegWrite_i  (wbReg.regWrite),
        .wbDest_i      (wbReg.dest),
        .branchTaken_i (branchTaken),
        .fwdA_o        (fwdA),
        .fwdB_o        (fwdB),
        .stall_o       (stall),
        .squash_o      (squash)
    );

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            exReg <= '0;
        end else if (stall) begin
            exReg <= '0; // bubble behind the load
        end else begin
            exReg <= '{pc: pcD, ctrl: ctrlD, rsVal: rsValD, rtVal: rtValD, imm: immD,
                       rs: instD.r.rs, rt: instD.r.rt, shamt: instD.r.shamt};
        end
    end

    executeUnit execute_i (
        .ex_i           (exReg),
        .fwdA_i         (fwdA),
        .fwdB_i         (fwdB),
        .memFwd_i       (memReg.aluOut),
        .wbFwd_i        (wbReg.result),
        .aluOut_o       (aluOutE),
        .storeData_o    (storeDataE),
        .branchTaken_o  (branchTaken),
        .branchTarget_o (branchTarget)
    );

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            memReg <= '0;
        end else begin
            memReg <= '{pc: exReg.pc, ctrl: exReg.ctrl, aluOut: aluOutE, storeData: storeDataE};
        end
    end

    // data memory answers in the same cycle
    assign memEn_o = memReg.ctrl.memRead || memReg.ctrl.memWrite;
    assign memWe_o = memReg.ctrl.memWrite;
    assign memAddr_o = memReg.aluOut;
    assign memWdata_o = memReg.storeData;
    assign memResult = memReg.ctrl.memRead ? memRdata_i : memReg.aluOut;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            wbReg <= '0;
        end else begin
            wbReg <= '{pc: memReg.pc, regWrite: memReg.ctrl.regWrite,
                       dest: memReg.ctrl.dest, result: memResult};
        end
    end

    assign commit_o = '{valid: wbReg.regWrite && (wbReg.dest != '0), pc: wbReg.pc,
                        regNum: wbReg.dest, data: wbReg.result};

endmodule

//--- src/executeUnit.sv
`timescale 1ns/1ps

module executeUnit import mipsIsaPkg::*, pipeCtrlPkg::*; (
    input  exStage_t             ex_i,
    input  fwdSel_t              fwdA_i,
    input  fwdSel_t              fwdB_i,
    input  logic [dataWidth-1:0] memFwd_i,
    input  logic [dataWidth-1:0] wbFwd_i,
    output logic [dataWidth-1:0] aluOut_o,
    output logic [dataWidth-1:0] storeData_o,
    output logic                 branchTaken_o,
    output logic [dataWidth-1:0] branchTarget_o
);

    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] rtFwd;
    logic [dataWidth-1:0] opB;
    logic [4:0]           shiftAmt;

    function automatic logic [dataWidth-1:0] fwdMux(fwdSel_t sel, logic [dataWidth-1:0] regVal);
        case (sel)
            fwdMem:  return memFwd_i;
            fwdWb:   return wbFwd_i;
            default: return regVal;
        endcase
    endfunction

    always_comb begin
        opA = fwdMux(fwdA_i, ex_i.rsVal);
        rtFwd = fwdMux(fwdB_i, ex_i.rtVal);
        opB = ex_i.ctrl.useImm ? ex_i.imm : rtFwd;
        shiftAmt = ex_i.ctrl.shiftSa ? ex_i.shamt : opA[4:0]; // variable shift from rs
        case (ex_i.ctrl.aluOp)
            aluSub:  aluOut_o = opA - opB;
            aluAnd:  aluOut_o = opA & opB;
            aluOr:   aluOut_o = opA | opB;
            aluXor:  aluOut_o = opA ^ opB;
            aluNor:  aluOut_o = ~(opA | opB);
            aluSlt:  aluOut_o = {{(dataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
            aluSltu: aluOut_o = {{(dataWidth-1){1'b0}}, opA < opB};
            aluSll:  aluOut_o = opB << shiftAmt; // shifts act on rt
            aluSrl:  aluOut_o = opB >> shiftAmt;
            aluLui:  aluOut_o = {opB[15:0], 16'b0};
            default: aluOut_o = opA + opB; // also load/store address
        endcase
    end

    assign storeData_o = rtFwd;

    // beq/bne compare the forwarded registers, never the immediate
    assign branchTaken_o = ex_i.ctrl.branch && ((opA == rtFwd) != ex_i.ctrl.branchNe);
    assign branchTarget_o = ex_i.pc + 32'd4 + {ex_i.imm[29:0], 2'b00};

endmodule

//--- src/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit import mipsIsaPkg::*, pipeCtrlPkg::*; (
    input  regIdx_t decRs_i,
    input  regIdx_t decRt_i,
    input  regIdx_t exRs_i,
    input  regIdx_t exRt_i,
    input  ctrl_t   exCtrl_i,
    input  ctrl_t   memCtrl_i,
    input  logic    wbRegWrite_i,
    input  regIdx_t wbDest_i,
    input  logic    branchTaken_i,
    output fwdSel_t fwdA_o,
    output fwdSel_t fwdB_o,
    output logic    stall_o,
    output logic    squash_o
);

    logic loadInEx;

    // newest producer wins, memory before writeback
    function automatic fwdSel_t pickSrc(regIdx_t src);
        if (src == '0) begin
            return fwdReg;
        end
        if (memCtrl_i.regWrite && (memCtrl_i.dest == src)) begin
            return fwdMem;
        end
        if (wbRegWrite_i && (wbDest_i == src)) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    always_comb begin
        fwdA_o = pickSrc(exRs_i);
        fwdB_o = pickSrc(exRt_i);
    end

    // load data only exists in memory, so a direct user waits one cycle
    assign loadInEx = exCtrl_i.memRead && (exCtrl_i.dest != '0);
    assign stall_o = loadInEx && ((exCtrl_i.dest == decRs_i) || (exCtrl_i.dest == decRt_i));

    assign squash_o = branchTaken_i; // kills the fetch after the delay slot

endmodule

//--- src/regFile.sv
`timescale 1ns/1ps

module regFile import mipsIsaPkg::*; (
    input  logic                 clk,
    input  logic                 rstN_i,
    input  regIdx_t              raddrA_i,
    input  regIdx_t              raddrB_i,
    output logic [dataWidth-1:0] rdataA_o,
    output logic [dataWidth-1:0] rdataB_o,
    input  logic                 we_i,
    input  regIdx_t              waddr_i,
    input  logic [dataWidth-1:0] wdata_i
);

    logic [dataWidth-1:0] regs [1:31]; // r0 has no storage

    function automatic logic [dataWidth-1:0] readPort(regIdx_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (we_i && (addr == waddr_i)) begin
            return wdata_i; // writeback visible to decode in the same cycle
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        rdataA_o = readPort(raddrA_i);
        rdataB_o = readPort(raddrB_i);
    end

endmodule

//--- src/instDecoder.sv
`timescale 1ns/1ps

module instDecoder import mipsIsaPkg::*, pipeCtrlPkg::*; (
    input  instWord_t            inst_i,
    input  logic [dataWidth-1:0] pcPlus4_i,
    output ctrl_t                ctrl_o,
    output logic [dataWidth-1:0] imm_o,
    output logic [dataWidth-1:0] jumpTarget_o
);

    logic signExt;
    logic destRd;
    logic destRt;

    always_comb begin
        ctrl_o = '0;
        signExt = 1'b1;
        destRd = 1'b0;
        destRt = 1'b0;
        case (inst_i.r.op)
            opSpecial: begin
                destRd = 1'b1;
                case (inst_i.r.funct)
                    fnAddu:  ctrl_o.aluOp = aluAdd;
                    fnSubu:  ctrl_o.aluOp = aluSub;
                    fnAnd:   ctrl_o.aluOp = aluAnd;
                    fnOr:    ctrl_o.aluOp = aluOr;
                    fnXor:   ctrl_o.aluOp = aluXor;
                    fnNor:   ctrl_o.aluOp = aluNor;
                    fnSlt:   ctrl_o.aluOp = aluSlt;
                    fnSltu:  ctrl_o.aluOp = aluSltu;
                    fnSll:   ctrl_o.aluOp = aluSll;
                    fnSrl:   ctrl_o.aluOp = aluSrl;
                    default: destRd = 1'b0; // unknown funct gives a bubble
                endcase
                ctrl_o.shiftSa = (inst_i.r.funct == fnSll) || (inst_i.r.funct == fnSrl);
            end
            opAddiu, opLw: begin
                ctrl_o.useImm = 1'b1;
                ctrl_o.memRead = (inst_i.i.op == opLw);
                destRt = 1'b1;
            end
            opSlti: begin
                ctrl_o.aluOp = aluSlt;
                ctrl_o.useImm = 1'b1;
                destRt = 1'b1;
            end
            opAndi, opOri: begin
                ctrl_o.aluOp = (inst_i.i.op == opAndi) ? aluAnd : aluOr;
                ctrl_o.useImm = 1'b1;
                signExt = 1'b0;   // logical immediates are zero extended
                destRt = 1'b1;
            end
            opLui: begin
                ctrl_o.aluOp = aluLui;
                ctrl_o.useImm = 1'b1;
                destRt = 1'b1;
            end
            opSw: begin
                ctrl_o.useImm = 1'b1;
                ctrl_o.memWrite = 1'b1;
            end
            opBeq, opBne: begin
                ctrl_o.branch = 1'b1;
                ctrl_o.branchNe = (inst_i.i.op == opBne);
            end
            opJ:     ctrl_o.jump = 1'b1;
            default: ctrl_o = '0;
        endcase
        ctrl_o.dest = destRd ? inst_i.r.rd : (destRt ? inst_i.i.rt : '0);
        ctrl_o.regWrite = (destRd || destRt) && (ctrl_o.dest != '0); // r0 writes dropped here
    end

    assign imm_o = signExt ? {{16{inst_i.i.imm[15]}}, inst_i.i.imm} : {16'b0, inst_i.i.imm};

    // region of the delay slot plus the 26 bit index
    assign jumpTarget_o = {pcPlus4_i[31:28], inst_i.i.rs, inst_i.i.rt, inst_i.i.imm, 2'b00};

endmodule

//--- src/pipeCtrlPkg.sv
package pipeCtrlPkg;

    import mipsIsaPkg::*;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluLui
    } aluOp_t;

    // operand source for execute
    typedef enum logic [1:0] {
        fwdReg,
        fwdMem,
        fwdWb
    } fwdSel_t;

    // all zero is a bubble
    typedef struct packed {
        aluOp_t  aluOp;
        logic    useImm;   // operand b from immediate
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    branch;
        logic    branchNe; // bne when set, beq otherwise
        logic    jump;
        logic    shiftSa;  // shift by shamt field
        regIdx_t dest;
    } ctrl_t;

    typedef struct packed {
        logic [dataWidth-1:0] pc;
        ctrl_t                ctrl;
        logic [dataWidth-1:0] rsVal;
        logic [dataWidth-1:0] rtVal;
        logic [dataWidth-1:0] imm;
        regIdx_t              rs;
        regIdx_t              rt;
        logic [4:0]           shamt;
    } exStage_t;

    typedef struct packed {
        logic [dataWidth-1:0] pc;
        ctrl_t                ctrl;
        logic [dataWidth-1:0] aluOut;    // also the data address
        logic [dataWidth-1:0] storeData;
    } memStage_t;

    typedef struct packed {
        logic [dataWidth-1:0] pc;
        logic                 regWrite;
        regIdx_t              dest;
        logic [dataWidth-1:0] result;
    } wbStage_t;

    // retirement record seen outside the core
    typedef struct packed {
        logic                 valid;
        logic [dataWidth-1:0] pc;
        regIdx_t              regNum;
        logic [dataWidth-1:0] data;
    } commit_t;

endpackage

//--- src/mipsIsaPkg.sv
package mipsIsaPkg;

    localparam int dataWidth = 32;
    localparam logic [dataWidth-1:0] resetVector = 32'hbfc0_0000; // first fetch address

    typedef logic [4:0] regIdx_t;

    // supported primary opcodes
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddiu   = 6'h09,
        opSlti    = 6'h0a,
        opAndi    = 6'h0c,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcode_t;

    // function field of opSpecial
    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnSrl  = 6'h02,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnNor  = 6'h27,
        fnSlt  = 6'h2a,
        fnSltu = 6'h2b
    } funct_t;

    typedef struct packed {
        opcode_t    op;
        regIdx_t    rs;
        regIdx_t    rt;
        regIdx_t    rd;
        logic [4:0] shamt;
        funct_t     funct;
    } rType_t;

    // also the j view: {rs, rt, imm} is the 26 bit index
    typedef struct packed {
        opcode_t     op;
        regIdx_t     rs;
        regIdx_t     rt;
        logic [15:0] imm;
    } iType_t;

    typedef union packed {
        rType_t r;
        iType_t i;
    } instWord_t;

    localparam instWord_t instNop = '0; // sll r0, r0, 0

endpackage
